//--- logic/rv_isa_pkg.sv
/*
 * RV32I subset ISA definitions
 * Opcodes, instruction field widths, ALU operation codes and the
 * decoded-control bundle shared by the single-cycle core.
 */
package rv_isa_pkg;

    // ==========================================================
    // widths
    // ==========================================================
    localparam int unsigned xlen       = 32;
    localparam int unsigned opcode_w   = 7;
    localparam int unsigned funct3_w   = 3;
    localparam int unsigned reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // ==========================================================
    // opcodes and function codes
    // ==========================================================
    typedef enum logic [opcode_w-1:0] {
        op_rtype  = 7'b0110011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111
    } opcode_e;

    localparam logic [funct3_w-1:0] f3_add_sub = 3'b000;
    localparam logic [funct3_w-1:0] f3_slt     = 3'b010;
    localparam logic [funct3_w-1:0] f3_or      = 3'b110;
    localparam logic [funct3_w-1:0] f3_and     = 3'b111;

    // instr[30], set for sub
    localparam int unsigned f7_sub_bit = 30;

    // ==========================================================
    // ALU operations and decoded control
    // ==========================================================
    typedef enum logic [2:0] {
        alu_and = 3'b000,
        alu_or  = 3'b001,
        alu_add = 3'b010,
        alu_sub = 3'b110,
        alu_slt = 3'b111
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;  // write-back from data memory
        logic    branch;      // beq
        logic    jal;
        logic    jalr;
        logic    alu_src;     // b operand is imm
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;  // sign-extended
    } decoded_t;

endpackage

//--- logic/rv_bus_pkg.sv
/*
 * Data-memory bus definitions
 * Wishbone classic request and response bundles, word-addressed,
 * whole 32-bit words only.
 */
package rv_bus_pkg;

    localparam int unsigned dmem_addr_w = 7;   // word address
    localparam int unsigned wb_data_w   = 32;

    // master to slave
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [dmem_addr_w-1:0] adr;
        logic [wb_data_w-1:0]   dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                 ack;
        logic [wb_data_w-1:0] dat;
    } wb_rsp_t;

endpackage

//--- logic/rv_decoder.sv
/*
 * Instruction decoder
 * Maps the opcode to control flags, extracts register indices,
 * picks the ALU operation and builds the sign-extended immediate.
 */
module rv_decoder import rv_isa_pkg::*; (
    input  word_t    instr,
    output decoded_t dec
);

    logic [funct3_w-1:0] funct3;
    alu_op_e             rtype_op;

    assign funct3 = instr[14:12];

    // R-type operation, unlisted combinations fall back to add
    always_comb begin
        case (funct3)
            f3_add_sub: rtype_op = instr[f7_sub_bit] ? alu_sub : alu_add;
            f3_slt:     rtype_op = alu_slt;
            f3_or:      rtype_op = alu_or;
            f3_and:     rtype_op = alu_and;
            default:    rtype_op = alu_add;
        endcase
    end

    always_comb begin
        dec             = '0;
        dec.rs1         = instr[19:15];
        dec.rs2         = instr[24:20];
        dec.rd          = instr[11:7];
        dec.ctrl.alu_op = alu_add;

        case (opcode_e'(instr[opcode_w-1:0]))
            op_rtype: begin
                dec.ctrl.reg_write = 1'b1;
                dec.ctrl.alu_op    = rtype_op;
            end
            op_load: begin
                dec.ctrl.reg_write  = 1'b1;
                dec.ctrl.mem_read   = 1'b1;
                dec.ctrl.mem_to_reg = 1'b1;
                dec.ctrl.alu_src    = 1'b1;
                dec.imm = {{20{instr[31]}}, instr[31:20]};  // I
            end
            op_store: begin
                dec.ctrl.mem_write = 1'b1;
                dec.ctrl.alu_src   = 1'b1;
                dec.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};  // S
            end
            op_branch: begin
                dec.ctrl.branch = 1'b1;
                dec.ctrl.alu_op = alu_sub;
                dec.imm = {{19{instr[31]}}, instr[31], instr[7],
                           instr[30:25], instr[11:8], 1'b0};  // B
            end
            op_jal: begin
                dec.ctrl.reg_write = 1'b1;
                dec.ctrl.jal       = 1'b1;
                dec.imm = {{11{instr[31]}}, instr[31], instr[19:12],
                           instr[20], instr[30:21], 1'b0};  // J
            end
            op_jalr: begin
                dec.ctrl.reg_write = 1'b1;
                dec.ctrl.jalr      = 1'b1;
                dec.imm = {{20{instr[31]}}, instr[31:20]};  // I
            end
            default: begin
                // unknown opcode runs as a no-op
            end
        endcase
    end

endmodule

//--- logic/rv_reg_file.sv
/*
 * Register file
 * 32 x 32 bits, two combinational read ports and one write port.
 * x0 reads as zero and ignores writes.
 */
module rv_reg_file import rv_isa_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      we,
    input  reg_addr_t rd,
    input  word_t     wdata,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [2**reg_addr_w];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 hardwired
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- logic/rv_alu.sv
/*
 * Integer ALU
 * and, or, add, sub and signed slt, with an equality flag for beq.
 */
module rv_alu import rv_isa_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    zero
);

    always_comb begin
        case (op)
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_slt: result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            default: result = '0;
        endcase
    end

    assign zero = (a == b);  // same as a - b == 0

endmodule

//--- logic/rv_pc_unit.sv
/*
 * Program counter
 * Holds the PC and selects the next fetch address from jal, taken
 * beq, jalr or sequential flow. Frozen while hold is high.
 */
module rv_pc_unit import rv_isa_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  hold,
    input  ctrl_t ctrl,
    input  word_t imm,
    input  word_t rs1_val,
    input  logic  alu_zero,
    output word_t pc,
    output word_t pc_plus4
);

    word_t pc_q;
    word_t pc_next;
    word_t jalr_target;

    assign pc          = pc_q;
    assign pc_plus4    = pc_q + 32'd4;
    assign jalr_target = (rs1_val + imm) & ~32'd1;  // bit 0 cleared

    always_comb begin
        if (ctrl.jal || (ctrl.branch && alu_zero)) begin
            pc_next = pc_q + imm;
        end else if (ctrl.jalr) begin
            pc_next = jalr_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (!hold) begin
            pc_q <= pc_next;
        end
    end

endmodule

//--- logic/rv_lsu.sv
/*
 * Load/store unit
 * Wishbone classic master for lw and sw. Launches one registered
 * request per memory instruction and stalls the core until ack.
 */
module rv_lsu import rv_isa_pkg::*; import rv_bus_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  ctrl_t   ctrl,
    input  word_t   addr,        // ALU result
    input  word_t   store_data,
    output wb_req_t wb_req,
    input  wb_rsp_t wb_rsp,
    output logic    stall,
    output word_t   load_data
);

    logic                   busy_q;  // request on the bus
    logic                   we_q;
    logic [dmem_addr_w-1:0] adr_q;
    logic [wb_data_w-1:0]   dat_q;

    logic mem_op;
    logic launch;
    logic done;

    assign mem_op = ctrl.mem_read | ctrl.mem_write;
    assign launch = mem_op & ~busy_q;
    assign done   = busy_q & wb_rsp.ack;

    // ==========================================================
    // request state
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            we_q   <= 1'b0;
        end else if (done) begin
            busy_q <= 1'b0;
            we_q   <= 1'b0;
        end else if (launch) begin
            busy_q <= 1'b1;
            we_q   <= ctrl.mem_write;
        end
    end

    // payload, held stable while stb is up
    always_ff @(posedge clk) begin
        if (launch) begin
            adr_q <= addr[dmem_addr_w+1:2];
            dat_q <= store_data;
        end
    end

    assign wb_req = '{cyc: busy_q, stb: busy_q, we: we_q, adr: adr_q, dat: dat_q};

    // release the core on the ack edge
    assign stall     = mem_op & ~done;
    assign load_data = wb_rsp.dat;

endmodule

//--- logic/riscv_core.sv
/*
 * Single-cycle RV32I subset core
 * One instruction per clock from a combinational instruction port.
 * Data memory over Wishbone classic, memory ops stall until ack.
 */
module riscv_core import rv_isa_pkg::*; import rv_bus_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    output word_t   imem_addr,
    input  word_t   imem_data,
    output wb_req_t wb_req,
    input  wb_rsp_t wb_rsp
);

    decoded_t dec;
    word_t    rdata1;
    word_t    rdata2;
    word_t    alu_b;
    word_t    alu_result;
    logic     alu_zero;
    word_t    pc;
    word_t    pc_plus4;
    word_t    load_data;
    word_t    wb_data;
    logic     stall;

    // ==========================================================
    // fetch and decode
    // ==========================================================
    assign imem_addr = pc;

    rv_decoder decoder_i (
        .instr (imem_data),
        .dec   (dec)
    );

    rv_pc_unit pc_unit_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .hold     (stall),
        .ctrl     (dec.ctrl),
        .imm      (dec.imm),
        .rs1_val  (rdata1),
        .alu_zero (alu_zero),
        .pc       (pc),
        .pc_plus4 (pc_plus4)
    );

    // ==========================================================
    // execute, memory, write-back
    // ==========================================================
    rv_reg_file reg_file_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (dec.ctrl.reg_write & ~stall),  // no write while waiting
        .rd     (dec.rd),
        .wdata  (wb_data),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    assign alu_b = dec.ctrl.alu_src ? dec.imm : rdata2;

    rv_alu alu_i (
        .op     (dec.ctrl.alu_op),
        .a      (rdata1),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    rv_lsu lsu_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (dec.ctrl),
        .addr       (alu_result),
        .store_data (rdata2),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .stall      (stall),
        .load_data  (load_data)
    );

    // link address for jumps
    assign wb_data = (dec.ctrl.jal || dec.ctrl.jalr) ? pc_plus4 :
                     dec.ctrl.mem_to_reg             ? load_data :
                                                       alu_result;

endmodule

//--- bench/tb_clk_gen.sv
/*
 * Testbench clock and reset
 * 20-unit clock period, active-low reset held for 4 cycles.
 */
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int unsigned half_period  = 10;
    localparam int unsigned reset_cycles = 4;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;  // released on a rising edge
    end

endmodule

//--- bench/riscv_core_chk.sv
/*
 * Core bus and fetch checks
 * Reset state, Wishbone classic hold rules and PC freeze during
 * data-memory stalls. Bound into every riscv_core instance.
 */
module riscv_core_chk import rv_isa_pkg::*; import rv_bus_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input word_t   imem_addr,
    input wb_req_t wb_req,
    input wb_rsp_t wb_rsp
);

    int unsigned fail_count = 0;

    // ==========================================================
    // reset and bus framing
    // ==========================================================
    reset_state: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> (imem_addr == '0 && !wb_req.cyc && !wb_req.stb))
        else begin
            fail_count++;
            $error("PC or bus not cleared by reset");
        end

    cyc_is_stb: assert property (@(posedge clk) wb_req.cyc == wb_req.stb)
        else begin
            fail_count++;
            $error("cyc and stb differ");
        end

    // ==========================================================
    // request held through wait states
    // ==========================================================
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.we)
                                      && $stable(wb_req.adr) && $stable(wb_req.dat))
        else begin
            fail_count++;
            $error("request changed before ack");
        end

    stb_drop: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.stb && wb_rsp.ack |=> !wb_req.stb)
        else begin
            fail_count++;
            $error("stb still high after the ack edge");
        end

    // fetch frozen while the slave waits
    pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.stb && !wb_rsp.ack |=> $stable(imem_addr))
        else begin
            fail_count++;
            $error("PC moved during a stall");
        end

    pc_after_store: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.stb && wb_rsp.ack && wb_req.we |=> imem_addr == $past(imem_addr) + 32'd4)
        else begin
            fail_count++;
            $error("PC did not step by 4 after a store");
        end

endmodule

bind riscv_core riscv_core_chk chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp)
);

//--- bench/tb_riscv_core.sv
/*
 * Testbench for the single-cycle core
 * Fixed program in a combinational instruction memory, a Wishbone
 * data-memory slave with random wait states, and an in-order list
 * of expected stores checked as they arrive.
 */
module tb_riscv_core import rv_isa_pkg::*; import rv_bus_pkg::*; ();

    // program length and 12 memory ops at 6 cycles each with 4x margin
    localparam int unsigned prog_len      = 28;
    localparam int unsigned mem_ops       = 12;
    localparam int unsigned timeout_limit = (prog_len + mem_ops * 6) * 4;

    logic    clk;
    logic    rst_n;
    word_t   imem_addr;
    word_t   imem_data;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    word_t       imem [64];
    word_t       mem  [2**dmem_addr_w];
    int unsigned n_instr = 0;
    logic        ack;
    word_t       rdat;
    logic        armed;      // wait count drawn for this request
    int unsigned wait_left;
    logic [31:0] rng;
    word_t       a_val;
    word_t       b_val;

    string                  exp_name [$];
    logic [dmem_addr_w-1:0] exp_adr  [$];
    word_t                  exp_dat  [$];
    int unsigned store_idx    = 0;
    int unsigned store_errors = 0;
    int unsigned cycles       = 0;
    logic        hung;

    tb_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

    riscv_core riscv_core_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp)
    );

    // misaligned or out-of-range fetch reads as a no-op
    assign imem_data = (imem_addr[31:8] == '0 && imem_addr[1:0] == 2'b00) ?
                       imem[imem_addr[7:2]] : '0;
    assign wb_rsp    = '{ack: ack, dat: rdat};

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // ==========================================================
    // instruction formats
    // ==========================================================
    function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                    input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), op_rtype};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input int rs1,
                                    input logic [2:0] f3, input int rd, input logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input int rs2, input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], op_store};  // sw
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input int rs1, input int rs2);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'b000, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), op_jal};
    endfunction

    task automatic emit(input word_t instr);
        imem[n_instr] = instr;
        n_instr++;
    endtask

    task automatic expect_store(input string name, input int byte_adr, input word_t data);
        exp_name.push_back(name);
        exp_adr.push_back(dmem_addr_w'(byte_adr >> 2));
        exp_dat.push_back(data);
    endtask

    // ==========================================================
    // data memory, Wishbone slave with 0 to 3 wait states
    // ==========================================================
    always @(posedge clk) begin
        if (!rst_n) begin
            ack   <= 1'b0;
            armed <= 1'b0;
        end else if (wb_req.stb && ack) begin  // transfer edge
            ack <= 1'b0;
            if (wb_req.we) begin
                mem[wb_req.adr] <= wb_req.dat;
                assert (store_idx < exp_dat.size())
                    else begin
                        store_errors++;
                        $display("store to word %0d came after the last expected one",
                                 wb_req.adr);
                    end
                if (store_idx < exp_dat.size()) begin
                    assert (wb_req.adr == exp_adr[store_idx] && wb_req.dat == exp_dat[store_idx])
                        else begin
                            store_errors++;
                            $display("FAILED %s: expected word %0d = %h, actual word %0d = %h",
                                     exp_name[store_idx], exp_adr[store_idx],
                                     exp_dat[store_idx], wb_req.adr, wb_req.dat);
                        end
                end
                store_idx <= store_idx + 1;
            end
        end else if (wb_req.stb && !armed) begin
            rng       <= xorshift32(rng);
            wait_left <= xorshift32(rng) % 4;
            armed     <= 1'b1;
        end else if (armed && wait_left == 0) begin
            ack   <= 1'b1;
            rdat  <= mem[wb_req.adr];
            armed <= 1'b0;
        end else if (armed) begin
            wait_left <= wait_left - 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        ack  = 1'b0;
        rdat = '0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;  // opcode 0 runs as a no-op
        end
        for (int i = 0; i < 2**dmem_addr_w; i++) begin
            mem[i] = 32'hc0de_0000 | 32'(i * 257);
        end
        a_val = xorshift32(32'hfc29);
        b_val = xorshift32(a_val);
        if (b_val == a_val) begin
            b_val = ~a_val;  // second beq must fall through
        end
        rng    = b_val;
        mem[0] = a_val;
        mem[1] = b_val;

        emit(enc_i(12'd0, 0, 3'b010, 1, op_load));      // pc 0 lw x1, 0(x0)
        emit(enc_i(12'd4, 0, 3'b010, 2, op_load));      // lw x2, 4(x0)
        emit(enc_r(7'd0, 2, 1, f3_add_sub, 3));
        emit(enc_s(12'd16, 3, 0));
        emit(enc_r(7'b0100000, 2, 1, f3_add_sub, 4));   // pc 16 sub
        emit(enc_s(12'd20, 4, 0));
        emit(enc_r(7'd0, 2, 1, f3_and, 5));
        emit(enc_s(12'd24, 5, 0));
        emit(enc_r(7'd0, 2, 1, f3_or, 6));              // pc 32
        emit(enc_s(12'd28, 6, 0));
        emit(enc_r(7'd0, 2, 1, f3_slt, 7));
        emit(enc_s(12'd32, 7, 0));
        emit(enc_r(7'd0, 1, 2, f3_slt, 8));             // pc 48 slt x8, x2, x1
        emit(enc_s(12'd36, 8, 0));
        emit(enc_r(7'd0, 2, 1, f3_add_sub, 0));         // write to x0
        emit(enc_s(12'd40, 0, 0));
        emit(enc_b(13'd8, 1, 1));                       // pc 64 beq taken
        emit(enc_s(12'd44, 1, 0));                      // skipped marker
        emit(enc_b(13'd8, 1, 2));                       // pc 72 beq not taken
        emit(enc_s(12'd48, 2, 0));
        emit(enc_j(21'd8, 9));                          // pc 80 jal x9, +8
        emit(enc_s(12'd44, 1, 0));
        emit(enc_s(12'd52, 9, 0));
        emit(enc_i(12'd105, 0, 3'b000, 10, op_jalr));   // pc 92 jalr to 105 with bit 0 cleared
        emit(enc_s(12'd44, 1, 0));
        emit(enc_s(12'd44, 1, 0));
        emit(enc_s(12'd56, 10, 0));                     // pc 104
        emit(enc_j(21'd0, 0));                          // park

        expect_store("add", 16, a_val + b_val);
        expect_store("sub", 20, a_val - b_val);
        expect_store("and", 24, a_val & b_val);
        expect_store("or", 28, a_val | b_val);
        expect_store("slt a b", 32, ($signed(a_val) < $signed(b_val)) ? 32'd1 : 32'd0);
        expect_store("slt b a", 36, ($signed(b_val) < $signed(a_val)) ? 32'd1 : 32'd0);
        expect_store("x0 write", 40, 32'd0);
        expect_store("beq not taken", 48, b_val);
        expect_store("jal link", 52, 32'd80 + 32'd4);
        expect_store("jalr link", 56, 32'd92 + 32'd4);

        while (store_idx < exp_dat.size() && cycles < timeout_limit) begin
            @(negedge clk);
        end
        hung = (store_idx < exp_dat.size());
        if (hung) begin
            $display("run hung: %0d of %0d stores seen within %0d cycles",
                     store_idx, exp_dat.size(), timeout_limit);
        end else begin
            repeat (4) @(negedge clk);  // room for a stray store
            assert (store_idx == exp_dat.size())
                else begin
                    store_errors++;
                    $display("%0d stores seen, %0d expected", store_idx, exp_dat.size());
                end
        end
        $display("errors: %0d store, %0d bus assertion, %0d timeout",
                 store_errors, riscv_core_i.chk_i.fail_count, hung);
        if (store_errors == 0 && riscv_core_i.chk_i.fail_count == 0 && !hung) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- build.f
logic/rv_isa_pkg.sv
logic/rv_bus_pkg.sv
logic/rv_decoder.sv
logic/rv_reg_file.sv
logic/rv_alu.sv
logic/rv_pc_unit.sv
logic/rv_lsu.sv
logic/riscv_core.sv
bench/tb_clk_gen.sv
bench/riscv_core_chk.sv
bench/tb_riscv_core.sv

//--- Bender.yml
package:
  name: riscv_core

sources:
  - files:
      - logic/rv_isa_pkg.sv
      - logic/rv_bus_pkg.sv
      - logic/rv_decoder.sv
      - logic/rv_reg_file.sv
      - logic/rv_alu.sv
      - logic/rv_pc_unit.sv
      - logic/rv_lsu.sv
      - logic/riscv_core.sv
  - target: simulation
    files:
      - bench/tb_clk_gen.sv
      - bench/riscv_core_chk.sv
      - bench/tb_riscv_core.sv
